// File: verilog/tetris_macros.svh
`ifndef TETRIS_MACROS_SVH
`define TETRIS_MACROS_SVH

// Row 0 is the top of the board and row 19 the floor
`define TETRIS_ROWS 20
`define TETRIS_COLS 10

// Queue slots and the generator's starting credit
`define TETRIS_QUEUE_DEPTH 4

// Galois LFSR that shifts right
`define TETRIS_LFSR_SEED 16'hACE1
`define TETRIS_LFSR_TAPS 16'hB400

// Column of the spawn anchor
// The shape window starts one column to its left
`define TETRIS_SPAWN_COL 4

`endif

// File: verilog/tetrisPkg.sv
`default_nettype none

`include "tetris_macros.svh"

package tetrisPkg;

    typedef enum logic [2:0] {
        LINE      = 3'd0,
        SQUARE    = 3'd1,
        L         = 3'd2,
        REVERSE_L = 3'd3,
        S         = 3'd4,
        Z         = 3'd5,
        T         = 3'd6
    } pieceKind; // 3'd7 is never issued

    typedef struct packed {
        pieceKind    kind;
        logic [11:0] serial; // Piece number from 0
    } pieceToken;

    typedef logic [`TETRIS_COLS-1:0] boardRow; // Bit c is column c

endpackage

`default_nettype wire

// File: verilog/pieceGenerator.sv
`timescale 1ns/1ps
`default_nettype none

`include "tetris_macros.svh"

module pieceGenerator (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 genCredit,
    output tetrisPkg::pieceToken genPiece,
    output logic                 genValid
);
    import tetrisPkg::*;

    localparam int creditBits = $clog2(`TETRIS_QUEUE_DEPTH + 1);

    logic [15:0]           lfsr;
    logic [15:0]           lfsrNext;
    logic [2:0]            draw;
    logic [creditBits-1:0] credit;
    logic [11:0]           serial;
    logic                  drawOk;
    logic                  issue;

    // Three LFSR steps, first bit out lands in draw[0]
    always_comb begin
        lfsrNext = lfsr;
        draw = '0;
        for (int i = 0; i < 3; i++) begin
            draw[i] = lfsrNext[0];
            lfsrNext = (lfsrNext >> 1) ^ (lfsrNext[0] ? `TETRIS_LFSR_TAPS : 16'h0000);
        end
    end

    assign drawOk = draw != 3'd7;
    assign issue  = drawOk && credit != '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr     <= `TETRIS_LFSR_SEED;
            credit   <= creditBits'(`TETRIS_QUEUE_DEPTH);
            serial   <= '0;
            genValid <= 1'b0;
        end else begin
            if (issue || !drawOk) begin // Hold a good draw while out of credit
                lfsr <= lfsrNext;
            end
            credit   <= credit - creditBits'(issue) + creditBits'(genCredit);
            serial   <= serial + 12'(issue);
            genValid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            genPiece <= '{kind: pieceKind'(draw), serial: serial};
        end
    end

    // Queue returns no more credit than it has slots
    assert property (@(posedge clk) disable iff (rst)
        credit <= creditBits'(`TETRIS_QUEUE_DEPTH));

endmodule

`default_nettype wire

// File: verilog/pieceQueue.sv
`timescale 1ns/1ps
`default_nettype none

`include "tetris_macros.svh"

module pieceQueue (
    input  logic                 clk,
    input  logic                 rst,
    input  tetrisPkg::pieceToken genPiece,
    input  logic                 genValid,
    output logic                 genCredit,
    output tetrisPkg::pieceToken nextPiece,
    output logic                 nextValid,
    input  logic                 nextCredit
);
    import tetrisPkg::*;

    localparam int ptrBits   = $clog2(`TETRIS_QUEUE_DEPTH);
    localparam int countBits = $clog2(`TETRIS_QUEUE_DEPTH + 1);

    pieceToken            slots [`TETRIS_QUEUE_DEPTH];
    logic [ptrBits-1:0]   wrPtr;
    logic [ptrBits-1:0]   rdPtr;
    logic [countBits-1:0] count;
    logic                 dropCredit; // Dropper's single slot credit
    logic                 pop;

    assign nextValid = dropCredit && count != '0;
    assign nextPiece = slots[rdPtr];
    assign pop       = nextValid;
    assign genCredit = pop; // Slot freed in the cycle it leaves

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wrPtr      <= '0;
            rdPtr      <= '0;
            count      <= '0;
            dropCredit <= 1'b1;
        end else begin
            if (genValid) begin
                wrPtr <= wrPtr + 1'b1; // Depth is a power of two
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            count      <= count + countBits'(genValid) - countBits'(pop);
            dropCredit <= (dropCredit && !pop) || nextCredit;
        end
    end

    always_ff @(posedge clk) begin
        if (genValid) begin
            slots[wrPtr] <= genPiece;
        end
    end

    // Generator credit keeps writes out of a full buffer
    assert property (@(posedge clk) disable iff (rst)
        genValid |-> count < countBits'(`TETRIS_QUEUE_DEPTH));

    // Every pop reads a slot that the write pointer has already filled
    assert property (@(posedge clk) disable iff (rst)
        pop |-> (rdPtr != wrPtr || count == countBits'(`TETRIS_QUEUE_DEPTH)));

endmodule

`default_nettype wire

// File: verilog/pieceDropper.sv
`timescale 1ns/1ps
`default_nettype none

`include "tetris_macros.svh"

module pieceDropper (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     step,
    input  tetrisPkg::pieceToken                     nextPiece,
    input  logic                                     nextValid,
    output logic                                     nextCredit,
    output tetrisPkg::boardRow [`TETRIS_ROWS-1:0]    board,
    output tetrisPkg::boardRow [`TETRIS_ROWS-1:0]    activeMask,
    output tetrisPkg::pieceKind                      activeKind,
    output logic [11:0]                              activeSerial,
    output logic                                     pieceLocked,
    output logic [15:0]                              linesCleared,
    output logic                                     gameOver
);
    import tetrisPkg::*;

    localparam int rowBits = $clog2(`TETRIS_ROWS);

    typedef enum logic [1:0] {IDLE, FALLING, CLEARING, OVER} dropState;

    // Element r is row offset r and bit i is column SPAWN_COL-1+i
    function automatic logic [3:0][3:0] shapeOf(pieceKind k);
        case (k)
            LINE:      shapeOf = {4'b0010, 4'b0010, 4'b0010, 4'b0010};
            SQUARE:    shapeOf = {4'b0000, 4'b0000, 4'b0110, 4'b0110};
            L:         shapeOf = {4'b0000, 4'b0110, 4'b0010, 4'b0010};
            REVERSE_L: shapeOf = {4'b0000, 4'b0110, 4'b0100, 4'b0100};
            S:         shapeOf = {4'b0000, 4'b0000, 4'b0110, 4'b1100};
            Z:         shapeOf = {4'b0000, 4'b0000, 4'b1100, 4'b0110};
            T:         shapeOf = {4'b0000, 4'b0000, 4'b0111, 4'b0010};
            default:   shapeOf = '0;
        endcase
    endfunction

    function automatic logic [2:0] shapeHeight(pieceKind k);
        case (k)
            LINE:         shapeHeight = 3'd4;
            L, REVERSE_L: shapeHeight = 3'd3;
            default:      shapeHeight = 3'd2;
        endcase
    endfunction

    // Rows past the floor are clipped
    function automatic logic [`TETRIS_ROWS-1:0][`TETRIS_COLS-1:0] placeShape(
        pieceKind k,
        logic [rowBits-1:0] top
    );
        logic [`TETRIS_ROWS-1:0][`TETRIS_COLS-1:0] m;
        logic [3:0][3:0] s;
        s = shapeOf(k);
        m = '0;
        for (int r = 0; r < 4; r++) begin
            if (int'(top) + r < `TETRIS_ROWS) begin
                m[int'(top) + r] = boardRow'(s[r]) << (`TETRIS_SPAWN_COL - 1);
            end
        end
        return m;
    endfunction

    dropState                         state;
    pieceToken                        active;
    logic [rowBits-1:0]               rowPos;  // Top row of the falling piece
    logic [rowBits-1:0]               scanRow; // Row under test while clearing
    boardRow [`TETRIS_ROWS-1:0]       curMask;
    boardRow [`TETRIS_ROWS-1:0]       lowerMask;
    boardRow [`TETRIS_ROWS-1:0]       spawnMask;
    boardRow [`TETRIS_ROWS-1:0]       shiftedBoard;
    logic                             canDrop;
    logic                             rowFull;
    logic                             clearDone;

    assign curMask   = placeShape(active.kind, rowPos);
    assign lowerMask = placeShape(active.kind, rowPos + 1'b1);
    assign spawnMask = placeShape(nextPiece.kind, '0);

    assign canDrop = (int'(rowPos) + int'(shapeHeight(active.kind)) < `TETRIS_ROWS)
                     && ((lowerMask & board) == '0);

    assign rowFull   = board[scanRow] == '1;
    assign clearDone = state == CLEARING && !rowFull && scanRow == '0;

    // Drop every row above the full one by one
    always_comb begin
        shiftedBoard = board;
        for (int r = 1; r < `TETRIS_ROWS; r++) begin
            if (r <= int'(scanRow)) begin
                shiftedBoard[r] = board[r - 1];
            end
        end
        shiftedBoard[0] = '0;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= IDLE;
            rowPos       <= '0;
            scanRow      <= '0;
            board        <= '0;
            linesCleared <= '0;
            pieceLocked  <= 1'b0;
        end else begin
            pieceLocked <= 1'b0;
            case (state)
                IDLE: begin
                    if (nextValid) begin
                        rowPos <= '0;
                        state  <= ((spawnMask & board) == '0) ? FALLING : OVER;
                    end
                end
                FALLING: begin
                    if (step && canDrop) begin
                        rowPos <= rowPos + 1'b1;
                    end else if (step) begin // Blocked below so lock in place
                        board       <= board | curMask;
                        pieceLocked <= 1'b1;
                        scanRow     <= rowBits'(`TETRIS_ROWS - 1);
                        state       <= CLEARING;
                    end
                end
                CLEARING: begin
                    if (rowFull) begin // Same row is checked again after the shift
                        board        <= shiftedBoard;
                        linesCleared <= linesCleared + 16'd1;
                    end else if (scanRow == '0) begin
                        state <= IDLE;
                    end else begin
                        scanRow <= scanRow - 1'b1;
                    end
                end
                default: begin
                    // Game over freezes everything until reset
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && nextValid) begin
            active <= nextPiece;
        end
    end

    assign activeMask   = (state == FALLING || state == OVER) ? curMask : '0;
    assign activeKind   = active.kind;
    assign activeSerial = active.serial;
    assign gameOver     = state == OVER;
    assign nextCredit   = clearDone; // Slot credit back to the queue

    assert property (@(posedge clk) disable iff (rst)
        state == FALLING |-> $countones(activeMask) == 4);

    // Spawn and descent checks keep the falling piece off the stack
    assert property (@(posedge clk) disable iff (rst)
        state == FALLING |-> (activeMask & board) == '0);

endmodule

`default_nettype wire

// File: verilog/tetrisCore.sv
`timescale 1ns/1ps
`default_nettype none

`include "tetris_macros.svh"

module tetrisCore (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  step,
    output tetrisPkg::boardRow [`TETRIS_ROWS-1:0] board,
    output tetrisPkg::boardRow [`TETRIS_ROWS-1:0] activeMask,
    output tetrisPkg::pieceKind                   activeKind,
    output logic [11:0]                           activeSerial,
    output logic                                  pieceLocked,
    output logic [15:0]                           linesCleared,
    output logic                                  gameOver
);
    import tetrisPkg::*;

    pieceToken genPiece;
    logic      genValid;
    logic      genCredit;
    pieceToken nextPiece;
    logic      nextValid;
    logic      nextCredit;

    pieceGenerator generator (
        .clk       (clk),
        .rst       (rst),
        .genCredit (genCredit),
        .genPiece  (genPiece),
        .genValid  (genValid)
    );

    pieceQueue queue (
        .clk        (clk),
        .rst        (rst),
        .genPiece   (genPiece),
        .genValid   (genValid),
        .genCredit  (genCredit),
        .nextPiece  (nextPiece),
        .nextValid  (nextValid),
        .nextCredit (nextCredit)
    );

    pieceDropper dropper (
        .clk          (clk),
        .rst          (rst),
        .step         (step),
        .nextPiece    (nextPiece),
        .nextValid    (nextValid),
        .nextCredit   (nextCredit),
        .board        (board),
        .activeMask   (activeMask),
        .activeKind   (activeKind),
        .activeSerial (activeSerial),
        .pieceLocked  (pieceLocked),
        .linesCleared (linesCleared),
        .gameOver     (gameOver)
    );

endmodule

`default_nettype wire

// File: verification/tetrisCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "tetris_macros.svh"

module tetrisCoreTb;
    import tetrisPkg::*;

    localparam int cellCount  = `TETRIS_ROWS * `TETRIS_COLS;
    localparam int runLimit   = 20000; // Cycles allowed until game over
    localparam int tailCycles = 40;    // Frozen board watched this long

    logic                       clk;
    logic                       rst;
    logic                       step;
    boardRow [`TETRIS_ROWS-1:0] board;
    boardRow [`TETRIS_ROWS-1:0] activeMask;
    pieceKind                   activeKind;
    logic [11:0]                activeSerial;
    logic                       pieceLocked;
    logic [15:0]                linesCleared;
    logic                       gameOver;

    int                   mismatchCount;
    int                   problemCount;
    int                   gapLeft;
    int                   cycles;
    int                   prevCount;
    int                   lockCount;
    logic [15:0]          lockLines;
    logic                 lockSeen;
    logic                 overSeen;
    logic [31:0]          stimLfsr;
    logic [15:0]          modelLfsr;  // Mirror of the generator LFSR
    logic [11:0]          expectSerial;
    logic [cellCount-1:0] prevMask;
    logic [cellCount-1:0] overBoard;

    tetrisCore UUT (
        .clk          (clk),
        .rst          (rst),
        .step         (step),
        .board        (board),
        .activeMask   (activeMask),
        .activeKind   (activeKind),
        .activeSerial (activeSerial),
        .pieceLocked  (pieceLocked),
        .linesCleared (linesCleared),
        .gameOver     (gameOver)
    );

    function automatic logic nextStimBit();
        logic outBit;
        outBit   = stimLfsr[0];
        stimLfsr = (stimLfsr >> 1) ^ (outBit ? 32'h80200003 : 32'h00000000);
        return outBit;
    endfunction

    // Three shifts per draw, first bit out is the kind's LSB, 7 drawn again
    function automatic logic [2:0] nextModelKind();
        logic [2:0] kind;
        kind = 3'd7;
        while (kind == 3'd7) begin
            for (int i = 0; i < 3; i++) begin
                kind[i]   = modelLfsr[0];
                modelLfsr = (modelLfsr >> 1) ^ (modelLfsr[0] ? `TETRIS_LFSR_TAPS : 16'h0000);
            end
        end
        return kind;
    endfunction

    function automatic logic hasFullRow(logic [cellCount-1:0] cells);
        for (int r = 0; r < `TETRIS_ROWS; r++) begin
            if (cells[r*`TETRIS_COLS +: `TETRIS_COLS] == '1) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic reportMismatch(string testName, logic [cellCount-1:0] expected,
                                  logic [cellCount-1:0] actual);
        mismatchCount++;
        $display("FAIL %s expected %0h actual %0h at %0t", testName, expected, actual, $time);
    endtask

    task automatic reportProblem(string text);
        problemCount++;
        $display("ERROR %s at %0t", text, $time);
    endtask

    task automatic checkReset();
        assert (board == '0) else reportMismatch("resetBoard", '0, board);
        assert (!pieceLocked) else reportMismatch("resetLocked", '0, cellCount'(pieceLocked));
        assert (!gameOver) else reportMismatch("resetGameOver", '0, cellCount'(gameOver));
        assert (linesCleared == '0) else reportMismatch("resetLines", '0, cellCount'(linesCleared));
    endtask

    // Outputs seen here follow the rising edge that sampled the current step
    task automatic checkCycle();
        logic [cellCount-1:0] mask;
        logic [cellCount-1:0] cells;
        logic [2:0]           expKind;
        int                   boardCount;
        int                   expCount;
        mask       = activeMask;
        cells      = board;
        boardCount = $countones(cells);
        if (overSeen) begin
            assert (gameOver) else reportProblem("gameOver fell after it was raised");
            assert (!pieceLocked) else reportProblem("pieceLocked pulsed after game over");
            assert (cells == overBoard) else reportMismatch("frozenBoard", overBoard, cells);
        end else begin
            if (mask != '0 && prevMask == '0) begin // New piece just spawned
                expKind = nextModelKind();
                assert (activeKind == pieceKind'(expKind))
                    else reportMismatch("pieceKind", cellCount'(expKind), cellCount'(activeKind));
                assert (activeSerial == expectSerial)
                    else reportMismatch("pieceSerial", cellCount'(expectSerial),
                                        cellCount'(activeSerial));
                expectSerial = expectSerial + 12'd1;
                if (lockSeen) begin
                    expCount = lockCount - 10 * int'(linesCleared - lockLines);
                    assert (boardCount == expCount)
                        else reportMismatch("cellsAfterClear", cellCount'(expCount),
                                            cellCount'(boardCount));
                    assert (!hasFullRow(cells)) else reportProblem("full row left after clearing");
                end
            end else if (prevMask != '0) begin
                if (step) begin
                    assert (pieceLocked || mask == (prevMask << `TETRIS_COLS))
                        else reportMismatch("descent", prevMask << `TETRIS_COLS, mask);
                end else begin
                    assert (mask == prevMask) else reportMismatch("holdPosition", prevMask, mask);
                end
            end
            if (pieceLocked) begin
                assert (boardCount == prevCount + 4)
                    else reportMismatch("cellsAtLock", cellCount'(prevCount + 4),
                                        cellCount'(boardCount));
                lockSeen  = 1'b1;
                lockCount = boardCount;
                lockLines = linesCleared;
            end
            if (gameOver) begin
                overSeen  = 1'b1;
                overBoard = cells;
            end
        end
        prevMask  = mask;
        prevCount = boardCount;
    endtask

    task automatic driveStep();
        logic [2:0] gap;
        if (gapLeft == 0) begin
            step = 1'b1;
            for (int i = 0; i < 3; i++) begin
                gap[i] = nextStimBit();
            end
            gapLeft = int'(gap) + 1; // One to eight idle cycles
        end else begin
            step = 1'b0;
            gapLeft--;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rst           = 1'b1;
        step          = 1'b0;
        mismatchCount = 0;
        problemCount  = 0;
        gapLeft       = 0;
        prevCount     = 0;
        lockCount     = 0;
        lockLines     = '0;
        lockSeen      = 1'b0;
        overSeen      = 1'b0;
        stimLfsr      = 32'd70209;
        modelLfsr     = `TETRIS_LFSR_SEED;
        expectSerial  = '0;
        prevMask      = '0;
        overBoard     = '0;
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            checkReset();
        end
        rst    = 1'b0;
        cycles = 0;
        while (!overSeen && cycles < runLimit) begin
            @(negedge clk);
            if (cycles == 0) begin
                checkReset(); // First cycle out of reset
            end
            checkCycle();
            driveStep();
            cycles++;
        end
        if (!overSeen) begin
            reportProblem("timed out waiting for gameOver");
        end
        for (int i = 0; i < tailCycles; i++) begin
            @(negedge clk);
            checkCycle();
            driveStep();
        end
        $display("Run ended after %0d cycles with %0d value mismatches and %0d other failures",
                 cycles, mismatchCount, problemCount);
        if (mismatchCount == 0 && problemCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tetrisCore.f
+incdir+verilog
verilog/tetrisPkg.sv
verilog/pieceGenerator.sv
verilog/pieceQueue.sv
verilog/pieceDropper.sv
verilog/tetrisCore.sv
verification/tetrisCoreTb.sv

// File: runSim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tetrisCoreTb -f tetrisCore.f -o tetrisSim || exit 1

simOutput=$(./obj_dir/tetrisSim)
echo "$simOutput"

echo "$simOutput" | grep -q "Simulation PASSED" && exit 0 || exit 1
